// File: hdl/uart_echo_pkg.sv
`default_nettype none

package uart_echo_pkg;

    // Status levels reported by the external UART chip
    typedef struct packed {
        logic data_ready;
        logic tbre;
        logic tsre;
    } uart_status_t;

    // Active-low strobes towards the UART chip
    typedef struct packed {
        logic rdn;
        logic wrn;
    } uart_strobe_t;

    // Two seven-segment patterns, bit 0 = a through bit 6 = g, active high
    typedef struct packed {
        logic [6:0] hi;
        logic [6:0] lo;
    } seg_pair_t;

    // Controller sequence, one step per state except the three wait states
    typedef enum logic [3:0] {
        INIT         = 4'd0,
        WAIT_RX      = 4'd1,
        READ_STROBE  = 4'd2,
        CAPTURE      = 4'd3,
        WRITE_SETUP  = 4'd4,
        WRITE_STROBE = 4'd5,
        WAIT_TBRE    = 4'd6,
        WAIT_TSRE    = 4'd7,
        WRITE_DONE   = 4'd8
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/hex_to_segments.sv
`default_nettype none

module hex_to_segments (
    input  wire logic [3:0] nibble,
    output logic      [6:0] segments
);

    // Patterns are gfedcba, a segment is lit when its bit is high
    always_comb begin
        case (nibble)
            4'h0: segments = 7'h3f;
            4'h1: segments = 7'h06;
            4'h2: segments = 7'h5b;
            4'h3: segments = 7'h4f;
            4'h4: segments = 7'h66;
            4'h5: segments = 7'h6d;
            4'h6: segments = 7'h7d;
            4'h7: segments = 7'h07;
            4'h8: segments = 7'h7f;
            4'h9: segments = 7'h6f;
            // Letters, b and d in lower case so they differ from 8 and 0
            4'ha: segments = 7'h77;
            4'hb: segments = 7'h7c;
            4'hc: segments = 7'h39;
            4'hd: segments = 7'h5e;
            4'he: segments = 7'h79;
            4'hf: segments = 7'h71;
            default: segments = 7'h00;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/byte_display.sv
`default_nettype none

module byte_display
    import uart_echo_pkg::*;
(
    input  wire logic       CLK,
    input  wire logic       RST,
    input  wire logic [7:0] rx_byte,
    input  wire logic       rx_strobe,
    output logic      [7:0] lights,
    output seg_pair_t       segs
);

    logic [7:0] shown_byte;
    logic [6:0] seg_hi;
    logic [6:0] seg_lo;

    // Holds the received byte while the bus later carries the echo
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            shown_byte <= 8'h00;
        end else if (rx_strobe) begin
            shown_byte <= rx_byte;
        end
    end

    assign lights = shown_byte;

    // Upper nibble on the left digit
    hex_to_segments u_hex_hi (
        .nibble   (shown_byte[7:4]),
        .segments (seg_hi)
    );

    hex_to_segments u_hex_lo (
        .nibble   (shown_byte[3:0]),
        .segments (seg_lo)
    );

    assign segs.hi = seg_hi;
    assign segs.lo = seg_lo;

endmodule

`default_nettype wire

// File: hdl/uart_bus_ctrl.sv
`default_nettype none

module uart_bus_ctrl
    import uart_echo_pkg::*;
#(
    parameter int STEP_LOG2 = 5
) (
    input  wire logic         CLK,
    input  wire logic         RST,

    // Chip side of the shared data bus
    input  wire uart_status_t status,
    input  wire logic [7:0]   bus_in,
    output uart_strobe_t      strobes,
    output logic      [7:0]   bus_out,
    output logic              bus_oe,

    // Towards the display
    output logic      [7:0]   rx_byte,
    output logic              rx_strobe
);

    //////////////////////////////
    // Step prescaler
    //////////////////////////////

    logic [STEP_LOG2-1:0] step_cnt;
    logic                 step_end;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            step_cnt <= '0;
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // Last cycle of a step before the counter wraps
    assign step_end = (step_cnt == {STEP_LOG2{1'b1}});

    //////////////////////////////
    // Sequencing FSM
    //////////////////////////////

    ctrl_state_e state;
    ctrl_state_e next_state;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state <= INIT;
        end else if (step_end) begin
            state <= next_state;
        end
    end

    // Used only at a step end so flags are sampled once per step
    always_comb begin
        next_state = state;
        case (state)
            INIT: begin
                next_state = WAIT_RX;
            end
            WAIT_RX: begin
                if (status.data_ready) begin
                    next_state = READ_STROBE;
                end
            end
            READ_STROBE: begin
                next_state = CAPTURE;
            end
            CAPTURE: begin
                next_state = WRITE_SETUP;
            end
            // Bus is driven here one step ahead of the write strobe
            WRITE_SETUP: begin
                next_state = WRITE_STROBE;
            end
            WRITE_STROBE: begin
                next_state = WAIT_TBRE;
            end
            WAIT_TBRE: begin
                if (status.tbre) begin
                    next_state = WAIT_TSRE;
                end
            end
            WAIT_TSRE: begin
                if (status.tsre) begin
                    next_state = WRITE_DONE;
                end
            end
            // Loop back for the next byte
            WRITE_DONE: begin
                next_state = WAIT_RX;
            end
            default: begin
                next_state = INIT;
            end
        endcase
    end

    //////////////////////////////
    // Strobes and bus direction
    //////////////////////////////

    // Low for exactly one step each
    assign strobes.rdn = (state != READ_STROBE);
    assign strobes.wrn = (state != WRITE_STROBE);

    // Held from setup until the shift register has drained
    always_comb begin
        case (state)
            WRITE_SETUP,
            WRITE_STROBE,
            WAIT_TBRE,
            WAIT_TSRE: begin
                bus_oe = 1'b1;
            end
            default: begin
                bus_oe = 1'b0;
            end
        endcase
    end

    //////////////////////////////
    // Captured byte and echo
    //////////////////////////////

    logic       capture_en;
    logic [7:0] data_q;

    // Last cycle of the read strobe while the chip still drives the bus
    assign capture_en = step_end && (state == READ_STROBE);

    always_ff @(posedge CLK) begin
        if (capture_en) begin
            data_q <= bus_in;
        end
    end

    assign rx_strobe = capture_en;

    // The display loads on the same edge as data_q and takes the
    // byte straight from the bus in the capture cycle
    assign rx_byte = capture_en ? bus_in : data_q;

    // Echo value wraps 8'hff to 8'h00
    assign bus_out = data_q + 8'd1;

endmodule

`default_nettype wire

// File: hdl/uart_echo_top.sv
`default_nettype none

module uart_echo_top
    import uart_echo_pkg::*;
#(
    parameter int STEP_LOG2 = 5
) (
    input  wire logic         CLK,
    input  wire logic         RST,

    // UART chip bus split into in, out and enable for the pad wrapper
    input  wire uart_status_t status,
    input  wire logic [7:0]   bus_in,
    output uart_strobe_t      strobes,
    output logic      [7:0]   bus_out,
    output logic              bus_oe,

    // Board display
    output logic      [7:0]   lights,
    output seg_pair_t         segs,

    // RAM sharing the data bus is kept off
    output logic              ram_en,
    output logic              ram_oe,
    output logic              ram_we
);

    //////////////////////////////
    // Internal connections
    //////////////////////////////

    logic [7:0] rx_byte;
    logic       rx_strobe;

    uart_bus_ctrl #(
        .STEP_LOG2 (STEP_LOG2)
    ) u_ctrl (
        .CLK       (CLK),
        .RST       (RST),
        .status    (status),
        .bus_in    (bus_in),
        .strobes   (strobes),
        .bus_out   (bus_out),
        .bus_oe    (bus_oe),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe)
    );

    byte_display u_display (
        .CLK       (CLK),
        .RST       (RST),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe),
        .lights    (lights),
        .segs      (segs)
    );

    //////////////////////////////
    // RAM tie-offs
    //////////////////////////////

    // Active-low enables held inactive so the RAM never drives the bus
    assign ram_en = 1'b1;
    assign ram_oe = 1'b1;
    assign ram_we = 1'b1;

endmodule

`default_nettype wire

// File: testbench/uart_chip_model.sv
`default_nettype none

module uart_chip_model
    import uart_echo_pkg::*;
#(
    parameter int SEED = 32'h6c3f
) (
    input  wire logic         CLK,
    input  wire logic         RST,

    // Bytes handed in by the testbench one per pulse
    input  wire logic         push,
    input  wire logic [7:0]   push_byte,

    // Bus side of the chip
    input  wire uart_strobe_t strobes,
    input  wire logic [7:0]   bus_out,
    output uart_status_t      status,
    output logic      [7:0]   bus_in,

    // Echoes seen at the end of each write strobe
    output int                echo_count,
    output logic      [7:0]   last_echo
);

    logic [7:0]   rx_queue[$];
    uart_strobe_t prev_strobes;
    int           tbre_wait;
    int           tsre_wait;
    integer       seed;

    initial begin
        seed = SEED;
        status.data_ready = 1'b0;
        status.tbre = 1'b1;
        status.tsre = 1'b1;
        bus_in = 8'h00;
        echo_count = 0;
        last_echo = 8'h00;
        prev_strobes = 2'b11;
    end

    always @(posedge CLK) begin
        if (push) begin
            rx_queue.push_back(push_byte);
        end
    end

    //////////////////////////////
    // Bus side updated on the falling edge
    //////////////////////////////

    always @(negedge CLK) begin
        if (!RST) begin
            status.data_ready <= 1'b0;
            status.tbre <= 1'b1;
            status.tsre <= 1'b1;
            bus_in <= 8'h00;
            prev_strobes <= 2'b11;
        end else begin
            // Head byte on the bus for the whole read strobe
            if (!strobes.rdn && rx_queue.size() != 0) begin
                bus_in <= rx_queue[0];
            end else begin
                bus_in <= 8'h00;
            end

            if (!prev_strobes.rdn && strobes.rdn) begin
                void'(rx_queue.pop_front());
                status.data_ready <= 1'b0;
            end else begin
                status.data_ready <= (rx_queue.size() != 0);
            end

            // Transmit buffer empties first and the shift register after it
            if (!prev_strobes.wrn && strobes.wrn) begin
                last_echo <= bus_out;
                echo_count <= echo_count + 1;
                status.tbre <= 1'b0;
                status.tsre <= 1'b0;
                tbre_wait = 1 + ($unsigned($random(seed)) % 40);
                tsre_wait = 1 + ($unsigned($random(seed)) % 40);
            end else if (!status.tbre) begin
                if (tbre_wait <= 1) begin
                    status.tbre <= 1'b1;
                end else begin
                    tbre_wait = tbre_wait - 1;
                end
            end else if (!status.tsre) begin
                if (tsre_wait <= 1) begin
                    status.tsre <= 1'b1;
                end else begin
                    tsre_wait = tsre_wait - 1;
                end
            end

            prev_strobes <= strobes;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_uart_echo.sv
`default_nettype none

module tb_uart_echo
    import uart_echo_pkg::*;
();

    localparam int STEP_LOG2      = 2;
    localparam int NUM_BYTES      = 20;
    localparam int TIMEOUT_CYCLES = 20000;

    logic         CLK;
    logic         RST;
    uart_status_t status;
    logic [7:0]   bus_in;
    uart_strobe_t strobes;
    logic [7:0]   bus_out;
    logic         bus_oe;
    logic [7:0]   lights;
    seg_pair_t    segs;
    logic         ram_en;
    logic         ram_oe;
    logic         ram_we;

    logic         push;
    logic [7:0]   push_byte;
    int           echo_count;
    logic [7:0]   last_echo;

    integer       seed;
    logic [7:0]   sent_bytes[$];
    logic [7:0]   expected_byte;
    int           read_count = 0;
    int           write_count = 0;
    logic         display_pending = 1'b0;
    logic         tsre_after_write = 1'b1;
    uart_strobe_t prev_strobes = 2'b11;

    uart_echo_top #(
        .STEP_LOG2 (STEP_LOG2)
    ) uut (
        .CLK     (CLK),
        .RST     (RST),
        .status  (status),
        .bus_in  (bus_in),
        .strobes (strobes),
        .bus_out (bus_out),
        .bus_oe  (bus_oe),
        .lights  (lights),
        .segs    (segs),
        .ram_en  (ram_en),
        .ram_oe  (ram_oe),
        .ram_we  (ram_we)
    );

    uart_chip_model #(
        .SEED (32'h6c3f)
    ) chip (
        .CLK        (CLK),
        .RST        (RST),
        .push       (push),
        .push_byte  (push_byte),
        .strobes    (strobes),
        .bus_out    (bus_out),
        .status     (status),
        .bus_in     (bus_in),
        .echo_count (echo_count),
        .last_echo  (last_echo)
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    //////////////////////////////
    // Checking helpers
    //////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_condition(input bit cond, input string what);
        assert (cond) else report_failure(what);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] expected);
        assert (got === expected) else report_failure(
            $sformatf("mismatch %s: got 0x%02h expected 0x%02h", name, got, expected));
    endtask

    task automatic check_segments(input string name, input logic [6:0] got,
                                  input logic [6:0] expected);
        assert (got === expected) else report_failure(
            $sformatf("mismatch %s: got 0x%02h expected 0x%02h", name, got, expected));
    endtask

    // Active high with bit 0 = a through bit 6 = g
    function automatic logic [6:0] hex_pattern(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'b0111111;
            4'h1: return 7'b0000110;
            4'h2: return 7'b1011011;
            4'h3: return 7'b1001111;
            4'h4: return 7'b1100110;
            4'h5: return 7'b1101101;
            4'h6: return 7'b1111101;
            4'h7: return 7'b0000111;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1101111;
            4'ha: return 7'b1110111;
            4'hb: return 7'b1111100;
            4'hc: return 7'b0111001;
            4'hd: return 7'b1011110;
            4'he: return 7'b1111001;
            default: return 7'b1110001;
        endcase
    endfunction

    //////////////////////////////
    // Bus monitor
    //////////////////////////////

    always @(negedge CLK) begin
        if (RST) begin
            // One cycle after the read strobe has ended
            if (display_pending) begin
                expected_byte = sent_bytes[read_count - 1];
                check_byte("lights", lights, expected_byte);
                check_segments("segs.hi", segs.hi, hex_pattern(expected_byte[7:4]));
                check_segments("segs.lo", segs.lo, hex_pattern(expected_byte[3:0]));
                display_pending = 1'b0;
            end

            if (!strobes.rdn) begin
                check_condition(status.data_ready, "read strobe low while data_ready is low");
                check_condition(!bus_oe, "bus driven while the read strobe is low");
            end
            if (!strobes.wrn) begin
                check_condition(bus_oe, "write strobe low while the bus is not driven");
            end

            if (!prev_strobes.rdn && strobes.rdn) begin
                read_count = read_count + 1;
                check_condition(read_count <= sent_bytes.size(),
                                "read strobe with no byte delivered");
                display_pending = 1'b1;
            end

            if (prev_strobes.wrn && !strobes.wrn) begin
                check_condition(tsre_after_write, "new write before tsre rose");
                tsre_after_write = 1'b0;
            end else if (prev_strobes.wrn && strobes.wrn && status.tsre) begin
                tsre_after_write = 1'b1;
            end

            // Echo is the delivered byte plus one and wraps at 8'hff
            if (!prev_strobes.wrn && strobes.wrn) begin
                write_count = write_count + 1;
                check_condition(write_count <= read_count, "write without a preceding read");
                expected_byte = sent_bytes[write_count - 1] + 8'd1;
                check_byte("bus_out", bus_out, expected_byte);
            end
        end
        prev_strobes = strobes;
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic check_reset_values();
        check_byte("rdn", {7'd0, strobes.rdn}, 8'h01);
        check_byte("wrn", {7'd0, strobes.wrn}, 8'h01);
        check_byte("ram_en", {7'd0, ram_en}, 8'h01);
        check_byte("ram_oe", {7'd0, ram_oe}, 8'h01);
        check_byte("ram_we", {7'd0, ram_we}, 8'h01);
        check_byte("bus_oe", {7'd0, bus_oe}, 8'h00);
        check_byte("lights", lights, 8'h00);
        check_segments("segs.hi", segs.hi, hex_pattern(4'h0));
        check_segments("segs.lo", segs.lo, hex_pattern(4'h0));
    endtask

    // First byte is 8'hff so the wrap of the echo is covered
    task automatic send_bytes();
        logic [7:0] new_byte;
        int         gap;
        for (int i = 0; i < NUM_BYTES; i++) begin
            if (i == 0) begin
                new_byte = 8'hff;
            end else begin
                new_byte = 8'($random(seed));
            end
            gap = $unsigned($random(seed)) % 40;
            repeat (gap) @(negedge CLK);
            sent_bytes.push_back(new_byte);
            push <= 1'b1;
            push_byte <= new_byte;
            @(negedge CLK);
            push <= 1'b0;
        end
    endtask

    task automatic wait_for_writes(input int count);
        int cycles;
        cycles = 0;
        while (write_count < count) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                report_failure($sformatf("timeout waiting for %0d echoes, saw %0d",
                                         count, write_count));
            end else begin
                @(posedge CLK);
                cycles = cycles + 1;
            end
        end
    endtask

    // Last transfer is over once tsre is back and the bus is released
    task automatic wait_for_bus_release();
        int cycles;
        cycles = 0;
        while (bus_oe || !status.tsre) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                report_failure("timeout waiting for the bus to be released");
            end else begin
                @(posedge CLK);
                cycles = cycles + 1;
            end
        end
    endtask

    task automatic check_totals();
        check_byte("write_count", 8'(write_count), 8'(read_count));
        check_byte("read_count", 8'(read_count), 8'(NUM_BYTES));
        check_byte("echo_count", 8'(echo_count), 8'(NUM_BYTES));
        expected_byte = sent_bytes[NUM_BYTES - 1] + 8'd1;
        check_byte("last_echo", last_echo, expected_byte);
    endtask

    initial begin
        seed = 32'h6c3f;
        RST <= 1'b0;
        push <= 1'b0;
        push_byte <= 8'h00;
        repeat (3) @(negedge CLK);
        RST <= 1'b1;
        repeat (2) @(negedge CLK);
        check_reset_values();
        send_bytes();
        wait_for_writes(NUM_BYTES);
        wait_for_bus_release();
        check_totals();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/uart_echo_pkg.sv
hdl/hex_to_segments.sv
hdl/byte_display.sv
hdl/uart_bus_ctrl.sv
hdl/uart_echo_top.sv
testbench/uart_chip_model.sv
testbench/tb_uart_echo.sv

// File: run_sim.sh
#!/bin/sh
# Build the echo testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_uart_echo -Mdir obj_dir \
    && ./obj_dir/Vtb_uart_echo > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
